// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - source
    files:
      - source/common.sv
      - source/fetch_align.sv
      - source/compressed.sv
      - source/instr_decode.sv
      - source/fetch_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/fetch_stage_assert.sv
      - tb/tb_fetch_stage.sv

// ==== filelist.f ====
+incdir+source
source/common.sv
source/fetch_align.sv
source/compressed.sv
source/instr_decode.sv
source/fetch_stage.sv
tb/fetch_stage_assert.sv
tb/tb_fetch_stage.sv

// ==== source/common.sv ====
`include "common_defines.svh"

package common;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;    // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;    // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    // Same word, register view or store view
    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } instr_view_u;

    typedef struct packed {
        logic [31:0]                   pc;
        opcode_e                       opcode;
        logic [4:0]                    rd;
        logic [4:0]                    rs1;
        logic [4:0]                    rs2;
        logic [2:0]                    funct3;
        logic [6:0]                    funct7;
        logic [`INSTRUCTION_WIDTH-1:0] imm;
        logic                          is_compressed;
        logic                          illegal;
    } decoded_t;

    typedef struct packed {
        logic [`INSTRUCTION_WIDTH-1:0] raw;    // Upper half unused when compressed
        logic [31:0]                   pc;
    } fetch_item_t;

endpackage

// ==== source/common_defines.svh ====
`ifndef COMMON_DEFINES_SVH
`define COMMON_DEFINES_SVH

// Expanded instruction and memory word width
`define INSTRUCTION_WIDTH 32

// One halfword parcel
`define PARCEL_WIDTH 16

// Address of the first parcel after reset
`define RESET_PC 32'h0000_0000

// Parcel buffer depth in the aligner
`define BUF_PARCELS 4

`endif

// ==== source/compressed.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module compressed (
    input  logic [`INSTRUCTION_WIDTH-1:0] mem_instruction,
    output logic                          is_compressed,
    output logic                          illegal,
    output logic [`INSTRUCTION_WIDTH-1:0] instruction
);

    import common::*;

    logic [15:0] ci;        // Compressed parcel
    logic [2:0]  funct3;
    logic [4:0]  r_hi;      // rs1'/rd' in x8..x15
    logic [4:0]  r_lo;      // rs2'/rd' in x8..x15
    logic [11:0] imm6;
    logic [5:0]  shamt;

    assign ci     = mem_instruction[15:0];
    assign funct3 = ci[15:13];
    assign r_hi   = {2'b01, ci[9:7]};
    assign r_lo   = {2'b01, ci[4:2]};
    assign imm6   = {{7{ci[12]}}, ci[6:2]};    // Sign extended
    assign shamt  = {ci[12], ci[6:2]};

    always_comb
    begin : compressed_expand
        is_compressed = 1'b1;
        illegal       = 1'b0;
        instruction   = mem_instruction;    // Kept on illegal
        case (ci[1:0])
            2'b11:
            begin
                is_compressed = 1'b0;
            end
            2'b00:
            begin
                case (funct3)
                    3'b010:    // C.LW
                        instruction = {5'b0, ci[5], ci[12:10], ci[6], 2'b00,
                                       r_hi, 3'b010, r_lo, LOAD};
                    3'b110:    // C.SW
                        instruction = {5'b0, ci[5], ci[12], r_lo, r_hi, 3'b010,
                                       ci[11:10], ci[6], 2'b00, STORE};
                    default: illegal = 1'b1;
                endcase
            end
            2'b01:
            begin
                case (funct3)
                    3'b000:    // C.ADDI
                        instruction = {imm6, ci[11:7], 3'b000, ci[11:7], OP_IMM};
                    3'b010:    // C.LI
                        instruction = {imm6, 5'b0, 3'b000, ci[11:7], OP_IMM};
                    3'b011:
                    begin
                        if (ci[11:7] == 5'd2)
                            illegal = 1'b1;    // C.ADDI16SP
                        else                   // C.LUI
                            instruction = {{15{ci[12]}}, ci[6:2], ci[11:7], LUI};
                    end
                    3'b100:
                    begin
                        case (ci[11:10])
                            2'b00:    // C.SRLI
                                instruction = {6'b0, shamt, r_hi, 3'b101, r_hi, OP_IMM};
                            2'b01:    // C.SRAI
                                instruction = {6'b010000, shamt, r_hi, 3'b101, r_hi, OP_IMM};
                            2'b10:    // C.ANDI
                                instruction = {imm6, r_hi, 3'b111, r_hi, OP_IMM};
                            default:
                            begin
                                if (ci[12])
                                    illegal = 1'b1;    // RV64 only
                                else
                                    case (ci[6:5])
                                        2'b00:    // C.SUB
                                            instruction = {7'b0100000, r_lo, r_hi, 3'b000,
                                                           r_hi, OP};
                                        2'b01:    // C.XOR
                                            instruction = {7'b0, r_lo, r_hi, 3'b100, r_hi, OP};
                                        2'b10:    // C.OR
                                            instruction = {7'b0, r_lo, r_hi, 3'b110, r_hi, OP};
                                        default:  // C.AND
                                            instruction = {7'b0, r_lo, r_hi, 3'b111, r_hi, OP};
                                    endcase
                            end
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            default:
            begin
                case (funct3)
                    3'b000:    // C.SLLI
                        instruction = {6'b0, shamt, ci[11:7], 3'b001, ci[11:7], OP_IMM};
                    3'b100:
                    begin
                        if (ci[6:2] == 5'd0)
                            illegal = 1'b1;    // Jumps and EBREAK
                        else if (ci[12])       // C.ADD
                            instruction = {7'b0, ci[6:2], ci[11:7], 3'b000, ci[11:7], OP};
                        else                   // C.MV
                            instruction = {7'b0, ci[6:2], 5'b0, 3'b000, ci[11:7], OP};
                    end
                    default: illegal = 1'b1;
                endcase
            end
        endcase
    end

endmodule

// ==== source/fetch_align.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module fetch_align (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [2*`PARCEL_WIDTH-1:0] word,
    input  logic                       word_valid,
    output logic                       word_take,
    output common::fetch_item_t        item,
    output logic                       item_valid
);

    localparam int CNT_W = $clog2(`BUF_PARCELS + 1);

    logic [`BUF_PARCELS-1:0][`PARCEL_WIDTH-1:0] parcels_q;    // Index 0 is the head
    logic [`BUF_PARCELS-1:0][`PARCEL_WIDTH-1:0] parcels_d;
    logic [`BUF_PARCELS-1:0][`PARCEL_WIDTH-1:0] shifted;
    logic [CNT_W-1:0]                           count_q;
    logic [CNT_W-1:0]                           count_d;
    logic [CNT_W-1:0]                           remain;
    logic [1:0]                                 pop;      // Parcels leaving this cycle
    logic [31:0]                                pc_q;
    logic                                       head_is_32;
    logic                                       push;

    assign head_is_32 = parcels_q[0][1:0] == 2'b11;

    // Head instruction complete
    always_comb
    begin : head_check
        if (count_q == '0)
        begin
            item_valid = 1'b0;
        end
        else if (head_is_32)
        begin
            item_valid = count_q >= CNT_W'(2);
        end
        else
        begin
            item_valid = 1'b1;
        end
    end

    always_comb
    begin : pop_size
        if (!item_valid)
        begin
            pop = 2'd0;
        end
        else if (head_is_32)
        begin
            pop = 2'd2;
        end
        else
        begin
            pop = 2'd1;
        end
    end

    assign remain    = count_q - CNT_W'(pop);
    assign word_take = remain <= CNT_W'(`BUF_PARCELS - 2);    // Room for a whole word
    assign push      = word_valid && word_take;

    assign item = '{raw: {parcels_q[1], parcels_q[0]}, pc: pc_q};

    always_comb
    begin : next_state
        shifted   = parcels_q >> (pop * `PARCEL_WIDTH);
        parcels_d = shifted;
        count_d   = remain;
        if (push)
        begin
            // Low halfword is the older parcel
            parcels_d[remain]        = word[`PARCEL_WIDTH-1:0];
            parcels_d[remain + 1'b1] = word[2*`PARCEL_WIDTH-1:`PARCEL_WIDTH];
            count_d                  = remain + CNT_W'(2);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin : ctrl_regs
        if (!arst_n)
        begin
            count_q <= '0;
            pc_q    <= `RESET_PC;
        end
        else
        begin
            count_q <= count_d;
            pc_q    <= pc_q + {29'b0, pop, 1'b0};    // +2 or +4
        end
    end

    always_ff @(posedge clk)
    begin : parcel_regs
        parcels_q <= parcels_d;
    end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module fetch_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [2*`PARCEL_WIDTH-1:0] word,
    input  logic                       word_valid,
    output logic                       word_take,
    output common::decoded_t           out,
    output logic                       out_valid
);

    import common::*;

    fetch_item_t item;          // Aligned instruction and its pc
    logic        item_valid;

    fetch_align u_fetch_align (
        .clk        (clk),
        .arst_n     (arst_n),
        .word       (word),
        .word_valid (word_valid),
        .word_take  (word_take),
        .item       (item),
        .item_valid (item_valid)
    );

    instr_decode u_instr_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .item       (item),
        .item_valid (item_valid),
        .out        (out),
        .out_valid  (out_valid)
    );

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module instr_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  common::fetch_item_t item,
    input  logic                item_valid,
    output common::decoded_t    out,
    output logic                out_valid
);

    import common::*;

    logic [`INSTRUCTION_WIDTH-1:0] expanded;
    logic                          is_compressed;
    logic                          illegal;
    instr_view_u                   view;
    logic [`INSTRUCTION_WIDTH-1:0] imm;
    decoded_t                      decoded;

    compressed u_compressed (
        .mem_instruction (item.raw),
        .is_compressed   (is_compressed),
        .illegal         (illegal),
        .instruction     (expanded)
    );

    assign view = expanded;

    always_comb
    begin : imm_select
        case (view.r_fmt.opcode)
            LOAD, OP_IMM:    // I-type
                imm = {{20{view.r_fmt.funct7[6]}}, view.r_fmt.funct7, view.r_fmt.rs2};
            STORE:
                imm = {{20{view.s_fmt.imm_hi[6]}}, view.s_fmt.imm_hi, view.s_fmt.imm_lo};
            LUI:
                imm = {view.r_fmt.funct7, view.r_fmt.rs2, view.r_fmt.rs1,
                       view.r_fmt.funct3, 12'b0};
            default:
                imm = '0;    // OP has none
        endcase
    end

    always_comb
    begin : record
        decoded.pc            = item.pc;
        decoded.opcode        = view.r_fmt.opcode;
        decoded.rd            = view.r_fmt.rd;
        decoded.rs1           = view.r_fmt.rs1;
        decoded.rs2           = view.r_fmt.rs2;
        decoded.funct3        = view.r_fmt.funct3;
        decoded.funct7        = view.r_fmt.funct7;
        decoded.imm           = imm;
        decoded.is_compressed = is_compressed;
        decoded.illegal       = illegal;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin : valid_reg
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= item_valid;
    end

    always_ff @(posedge clk)
    begin : out_reg
        if (item_valid)
            out <= decoded;
    end

endmodule

// ==== tb/fetch_stage_assert.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module fetch_stage_assert (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic                                 word_valid,
    input logic                                 word_take,
    input logic                                 item_valid,
    input logic [$clog2(`BUF_PARCELS + 1)-1:0]  count,
    input logic [31:0]                          pc
);

    int violations = 0;    // Failure tally

    count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= `BUF_PARCELS)
    else
    begin
        violations++;
        $error("parcel count %0d above buffer capacity", count);
    end

    push_when_room: assert property (@(posedge clk) disable iff (!arst_n)
        word_valid |-> word_take)
    else
    begin
        violations++;
        $error("word_valid high while word_take low");
    end

    quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !item_valid)
    else
    begin
        violations++;
        $error("item_valid high right after reset release");
    end

    // Steps by one or two parcels when an item leaves and holds otherwise
    pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> ($past(item_valid) ? (32'(pc - $past(pc)) inside {32'd2, 32'd4})
                                             : (pc == $past(pc))))
    else
    begin
        violations++;
        $error("pc moved from %h to %h", $past(pc), pc);
    end

endmodule

bind fetch_align fetch_stage_assert u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .word_valid (word_valid),
    .word_take  (word_take),
    .item_valid (item_valid),
    .count      (count_q),
    .pc         (pc_q)
);

// ==== tb/tb_fetch_stage.sv ====
`timescale 1ns/1ns
`include "common_defines.svh"

module tb_fetch_stage;

    import common::*;

    localparam int PROGRAM_LEN    = 400;
    localparam int TIMEOUT_CYCLES = 4 * PROGRAM_LEN + 100;
    localparam int T_RESET   = 0;
    localparam int T_RV32    = 1;
    localparam int T_RVC     = 2;
    localparam int T_ILLEGAL = 3;
    localparam int T_PC      = 4;
    localparam int T_RULES   = 5;

    typedef struct packed {
        logic [15:0] parcel;
        logic [31:0] expanded;
    } rvc_pair_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] word;
    logic        word_valid;
    logic        word_take;
    decoded_t    out;
    logic        out_valid;

    integer      seed = 32'h173f_6019;
    decoded_t    exp_q[$];
    decoded_t    mask_q[$];
    int          kind_q[$];
    logic [31:0] words[$];
    int          checks[6];
    int          errors[6];
    int          received;
    int          cycles;
    string       test_name[6] = '{"reset_state", "rv32_decode", "rvc_expand",
                                  "rvc_illegal", "pc_sequence", "aligner_rules"};

    fetch_stage dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .word       (word),
        .word_valid (word_valid),
        .word_take  (word_take),
        .out        (out),
        .out_valid  (out_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Error: timeout after %0d cycles with %0d of %0d instructions decoded",
                     cycles, received, PROGRAM_LEN);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // RV32 base formats
    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // Parcel and its RV32 equivalent from the same random fields
    function automatic rvc_pair_t rvc_form(input int form, input logic [31:0] r);
        logic [4:0]  rd;
        logic [4:0]  lui_rd;
        logic [4:0]  rs2;
        logic [4:0]  rp1;
        logic [4:0]  rp2;
        logic [5:0]  imm;
        logic [11:0] simm;
        logic [4:0]  sh;
        logic [6:0]  uimm;
        rd     = r[20:16];
        lui_rd = (rd == 5'd2) ? 5'd3 : rd;    // x2 would be C.ADDI16SP
        rs2    = (r[25:21] == 5'd0) ? 5'd1 : r[25:21];
        rp1    = {2'b01, r[28:26]};
        rp2    = {2'b01, r[31:29]};
        imm    = r[5:0];
        simm   = {{6{imm[5]}}, imm};
        sh     = r[10:6];    // shamt[5] stays 0 on RV32
        uimm   = {r[15:11], 2'b00};
        case (form)
            0: return {3'b010, uimm[5:3], rp1[2:0], uimm[2], uimm[6], rp2[2:0], 2'b00,
                       i_word({5'b0, uimm}, rp1, 3'b010, rp2, LOAD)};
            1: return {3'b110, uimm[5:3], rp1[2:0], uimm[2], uimm[6], rp2[2:0], 2'b00,
                       s_word({5'b0, uimm}, rp2, rp1, 3'b010, STORE)};
            2: return {3'b000, imm[5], rd, imm[4:0], 2'b01, i_word(simm, rd, 3'b000, rd, OP_IMM)};
            3: return {3'b010, imm[5], rd, imm[4:0], 2'b01, i_word(simm, 5'd0, 3'b000, rd, OP_IMM)};
            4: return {3'b011, imm[5], lui_rd, imm[4:0], 2'b01, {14{imm[5]}}, imm, lui_rd, LUI};
            5: return {6'b100000, rp1[2:0], sh, 2'b01,
                       i_word({7'b0, sh}, rp1, 3'b101, rp1, OP_IMM)};
            6: return {6'b100001, rp1[2:0], sh, 2'b01,
                       i_word({7'b0100000, sh}, rp1, 3'b101, rp1, OP_IMM)};
            7: return {3'b100, imm[5], 2'b10, rp1[2:0], imm[4:0], 2'b01,
                       i_word(simm, rp1, 3'b111, rp1, OP_IMM)};
            8: return {6'b100011, rp1[2:0], 2'b00, rp2[2:0], 2'b01,
                       r_word(7'b0100000, rp2, rp1, 3'b000, rp1, OP)};
            9: return {6'b100011, rp1[2:0], 2'b01, rp2[2:0], 2'b01,
                       r_word(7'b0, rp2, rp1, 3'b100, rp1, OP)};
            10: return {6'b100011, rp1[2:0], 2'b10, rp2[2:0], 2'b01,
                        r_word(7'b0, rp2, rp1, 3'b110, rp1, OP)};
            11: return {6'b100011, rp1[2:0], 2'b11, rp2[2:0], 2'b01,
                        r_word(7'b0, rp2, rp1, 3'b111, rp1, OP)};
            12: return {4'b0000, rd, sh, 2'b10, i_word({7'b0, sh}, rd, 3'b001, rd, OP_IMM)};
            13: return {4'b1000, rd, rs2, 2'b10, r_word(7'b0, rs2, 5'd0, 3'b000, rd, OP)};
            default: return {4'b1001, rd, rs2, 2'b10, r_word(7'b0, rs2, rd, 3'b000, rd, OP)};
        endcase
    endfunction

    // Encodings outside the supported subset
    function automatic logic [15:0] illegal_parcel(input logic [31:0] r);
        case (r[31:30])
            2'd0: return {3'b000, r[12:2], 2'b00};           // C.ADDI4SPN
            2'd1: return {3'b101, r[12:2], 2'b01};           // C.J
            2'd2: return {3'b010, r[12:2], 2'b10};           // C.LWSP
            default: return {6'b100111, r[9:2], 2'b01};      // RV64 C.SUBW group
        endcase
    endfunction

    function automatic logic [6:0] pick_opcode(input int n);
        case (n)
            0: return LOAD;
            1: return STORE;
            2: return OP;
            3: return OP_IMM;
            default: return LUI;
        endcase
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] w);
        case (w[6:0])
            LOAD, OP_IMM: return {{20{w[31]}}, w[31:20]};
            STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
            LUI: return {w[31:12], 12'b0};
            default: return 32'b0;
        endcase
    endfunction

    function automatic decoded_t make_record(input logic [31:0] w, input logic c,
                                             input logic ill, input logic [31:0] pc);
        decoded_t rec;
        rec.pc            = pc;
        rec.opcode        = opcode_e'(w[6:0]);
        rec.rd            = w[11:7];
        rec.rs1           = w[19:15];
        rec.rs2           = w[24:20];
        rec.funct3        = w[14:12];
        rec.funct7        = w[31:25];
        rec.imm           = model_imm(w);
        rec.is_compressed = c;
        rec.illegal       = ill;
        return rec;
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] raw;
        logic [15:0] parcels[$];
        logic [31:0] pc;
        rvc_pair_t   pair;
        decoded_t    m;
        int          sel;
        int          i;
        pc = `RESET_PC;
        for (i = 0; i < PROGRAM_LEN; i++)
        begin
            sel = {$random(seed)} % 24;
            r   = $random(seed);
            m   = '1;
            m.pc = '0;    // Checked on its own
            if (sel < 15)
            begin
                pair = rvc_form(sel, r);
                raw  = {16'h0, pair.parcel};
                exp_q.push_back(make_record(pair.expanded, 1'b1, 1'b0, pc));
                kind_q.push_back(T_RVC);
            end
            else if (sel == 15)
            begin
                raw = {16'h0, illegal_parcel(r)};
                exp_q.push_back(make_record(raw, 1'b1, 1'b1, pc));
                kind_q.push_back(T_ILLEGAL);
                m.rs1    = 5'b00001;    // Upper half belongs to the next parcel
                m.rs2    = '0;
                m.funct7 = '0;
            end
            else
            begin
                raw = {r[31:7], pick_opcode({$random(seed)} % 5)};
                exp_q.push_back(make_record(raw, 1'b0, 1'b0, pc));
                kind_q.push_back(T_RV32);
            end
            mask_q.push_back(m);
            parcels.push_back(raw[15:0]);
            if (raw[1:0] == 2'b11)
                parcels.push_back(raw[31:16]);
            pc = pc + ((raw[1:0] == 2'b11) ? 32'd4 : 32'd2);
        end
        if (parcels.size() % 2 != 0)
            parcels.push_back(16'hffff);    // Lone half of a 32-bit instruction that never completes
        for (i = 0; i < parcels.size(); i += 2)
            words.push_back({parcels[i+1], parcels[i]});
    endtask

    task automatic collect_output();
        decoded_t e;
        decoded_t m;
        int       k;
        if (out_valid)
        begin
            received++;
            assert (exp_q.size() != 0)
            else
            begin
                $display("Error: out_valid pulsed with no instruction left to expect");
                errors[T_PC]++;
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                m = mask_q.pop_front();
                k = kind_q.pop_front();
                checks[k]++;
                checks[T_PC]++;
                assert (((out ^ e) & m) === '0)
                else
                begin
                    $display("FAILED %s: pc %h expected %h actual %h",
                             test_name[k], e.pc, e & m, out & m);
                    errors[k]++;
                end
                assert (out.pc === e.pc)
                else
                begin
                    $display("FAILED pc_sequence: expected %h actual %h", e.pc, out.pc);
                    errors[T_PC]++;
                end
            end
        end
    endtask

    task automatic print_test(input int t);
        $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
    endtask

    initial
    begin : main
        int gap;
        int next_word;
        int total_checks;
        int total_errors;
        int t;
        arst_n     = 1'b0;
        word       = '0;
        word_valid = 1'b0;
        received   = 0;
        cycles     = 0;
        gap        = 0;
        next_word  = 0;
        build_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (2)
        begin
            @(negedge clk);
            checks[T_RESET]++;
            assert (word_take === 1'b1 && out_valid === 1'b0)
            else
            begin
                $display("FAILED reset_state: word_take,out_valid expected 1,0 actual %b,%b",
                         word_take, out_valid);
                errors[T_RESET]++;
            end
        end
        print_test(T_RESET);

        while (received < PROGRAM_LEN)
        begin
            @(negedge clk);
            collect_output();
            word_valid = 1'b0;
            if (gap > 0)
                gap--;
            else if (next_word < words.size() && word_take)
            begin
                word       = words[next_word];
                word_valid = 1'b1;
                next_word++;
                gap = {$random(seed)} % 3;
            end
        end
        word_valid = 1'b0;
        repeat (5)    // Catch duplicates after the last one
        begin
            @(negedge clk);
            collect_output();
        end

        checks[T_PC]++;
        assert (received == PROGRAM_LEN)
        else
        begin
            $display("FAILED pc_sequence: instruction count expected %0d actual %0d",
                     PROGRAM_LEN, received);
            errors[T_PC]++;
        end
        for (t = T_RV32; t <= T_PC; t++)
            print_test(t);

        checks[T_RULES]++;
        assert (dut_i.u_fetch_align.u_assert.violations == 0)
        else
        begin
            $display("Error: the aligner broke its buffer rules %0d times",
                     dut_i.u_fetch_align.u_assert.violations);
            errors[T_RULES]++;
        end
        print_test(T_RULES);

        total_checks = 0;
        total_errors = 0;
        for (t = 0; t < 6; t++)
        begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("%0d tests, %0d checks, %0d errors", 6, total_checks, total_errors);
        if (total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
